//--- rdma_wr_pkg.sv
// RDMA write demux shared definitions

package rdma_wr_pkg;

  // --------------------------------------------------
  // Sizing
  // --------------------------------------------------

  // Virtual regions
  localparam int N_REGIONS      = 4;
  localparam int N_REGIONS_BITS = 2;

  // Command byte length
  localparam int LEN_BITS = 12;

  // Beat width, 8 bytes per beat
  localparam int DATA_BITS     = 64;
  localparam int BEAT_LOG_BITS = 3;

  // Commands with data still in flight
  localparam int N_OUTSTANDING = 8;

  // Per-region queue depths
  localparam int CMD_QUEUE_DEPTH = 4;
  localparam int DATA_FIFO_DEPTH = 16;

  // Write-ready threshold on data FIFO fill level
  localparam int WR_THRS = 8;

  // --------------------------------------------------
  // Types
  // --------------------------------------------------

  typedef logic [N_REGIONS_BITS-1:0] vfid_t;
  typedef logic [LEN_BITS-1:0]       len_t;
  typedef logic [DATA_BITS-1:0]      data_t;
  typedef logic [DATA_BITS/8-1:0]    keep_t;

  // Holds 0 up to DATA_FIFO_DEPTH inclusive
  typedef logic [$clog2(DATA_FIFO_DEPTH+1)-1:0] count_t;

endpackage

//--- meta_fifo.sv
// Valid/ready metadata FIFO
`timescale 1ns/1ps

// DEPTH is expected to be a power of two, pointers wrap on overflow
module meta_fifo #(
  parameter int WIDTH = 8,
  parameter int DEPTH = 4
) (
  input  logic             aclk,
  input  logic             aresetn,
  input  logic             in_valid,
  output logic             in_ready,
  input  logic [WIDTH-1:0] in_data,
  output logic             out_valid,
  input  logic             out_ready,
  output logic [WIDTH-1:0] out_data
);

  // Storage
  logic [WIDTH-1:0] mem [DEPTH];

  // Pointers and occupancy
  logic [$clog2(DEPTH)-1:0]   wr_ptr;
  logic [$clog2(DEPTH)-1:0]   rd_ptr;
  logic [$clog2(DEPTH+1)-1:0] count;

  logic wr_en;
  logic rd_en;

  // Handshakes
  assign wr_en = in_valid && in_ready;
  assign rd_en = out_valid && out_ready;

  // Ready only on free space
  assign in_ready  = (count != DEPTH);
  assign out_valid = (count != '0);

  // Head entry straight from storage, visible the cycle after its write
  assign out_data = mem[rd_ptr];

  always_ff @(posedge aclk) begin
    if (wr_en) begin
      mem[wr_ptr] <= in_data;
    end
  end

  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (wr_en) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (rd_en) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      // Simultaneous read and write leaves count unchanged
      case ({wr_en, rd_en})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

//--- axis_data_fifo.sv
// Stream data FIFO with fill level
`timescale 1ns/1ps

module axis_data_fifo (
  input  logic                aclk,
  input  logic                aresetn,
  input  logic                in_valid,
  output logic                in_ready,
  input  rdma_wr_pkg::data_t  in_data,
  input  rdma_wr_pkg::keep_t  in_keep,
  input  logic                in_last,
  output logic                out_valid,
  input  logic                out_ready,
  output rdma_wr_pkg::data_t  out_data,
  output rdma_wr_pkg::keep_t  out_keep,
  output logic                out_last,
  output rdma_wr_pkg::count_t count
);

  import rdma_wr_pkg::*;

  // Fill state, kept in step with count
  typedef enum logic [1:0] {
    FIFO_EMPTY,
    FIFO_PART,
    FIFO_FULL
  } fill_t;

  fill_t fill_q;
  fill_t fill_d;
  count_t count_d;

  // Beat storage
  data_t mem_data [DATA_FIFO_DEPTH];
  keep_t mem_keep [DATA_FIFO_DEPTH];
  logic  mem_last [DATA_FIFO_DEPTH];

  logic [$clog2(DATA_FIFO_DEPTH)-1:0] wr_ptr;
  logic [$clog2(DATA_FIFO_DEPTH)-1:0] rd_ptr;

  logic wr_en;
  logic rd_en;

  // --------------------------------------------------
  // Handshakes and flags
  // --------------------------------------------------

  assign wr_en = in_valid && in_ready;
  assign rd_en = out_valid && out_ready;

  // Flags come from the registered fill state
  assign in_ready  = (fill_q != FIFO_FULL);
  assign out_valid = (fill_q != FIFO_EMPTY);

  // Head beat
  assign out_data = mem_data[rd_ptr];
  assign out_keep = mem_keep[rd_ptr];
  assign out_last = mem_last[rd_ptr];

  // Next occupancy and fill state
  always_comb begin
    count_d = count;
    if (wr_en && !rd_en) begin
      count_d = count + 1'b1;
    end else if (!wr_en && rd_en) begin
      count_d = count - 1'b1;
    end

    if (count_d == '0) begin
      fill_d = FIFO_EMPTY;
    end else if (count_d == count_t'(DATA_FIFO_DEPTH)) begin
      fill_d = FIFO_FULL;
    end else begin
      fill_d = FIFO_PART;
    end
  end

  // --------------------------------------------------
  // Registers
  // --------------------------------------------------

  always_ff @(posedge aclk) begin
    if (wr_en) begin
      mem_data[wr_ptr] <= in_data;
      mem_keep[wr_ptr] <= in_keep;
      mem_last[wr_ptr] <= in_last;
    end
  end

  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
      fill_q <= FIFO_EMPTY;
    end else begin
      if (wr_en) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (rd_en) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      count  <= count_d;
      fill_q <= fill_d;
    end
  end

endmodule

//--- rdma_wr_demux.sv
// RDMA write command and data demux
`timescale 1ns/1ps

module rdma_wr_demux (
  input  logic                                              aclk,
  input  logic                                              aresetn,
  // Command in
  input  logic                                              req_valid,
  output logic                                              req_ready,
  input  rdma_wr_pkg::vfid_t                                req_vfid,
  input  rdma_wr_pkg::len_t                                 req_len,
  input  logic                                              req_last,
  // Data in, no tlast
  input  logic                                              wr_valid,
  output logic                                              wr_ready,
  input  rdma_wr_pkg::data_t                                wr_data,
  input  rdma_wr_pkg::keep_t                                wr_keep,
  // Per-region commands
  output logic [rdma_wr_pkg::N_REGIONS-1:0]                 out_req_valid,
  input  logic [rdma_wr_pkg::N_REGIONS-1:0]                 out_req_ready,
  output rdma_wr_pkg::len_t [rdma_wr_pkg::N_REGIONS-1:0]    out_req_len,
  output logic [rdma_wr_pkg::N_REGIONS-1:0]                 out_req_last,
  // Per-region data
  output logic [rdma_wr_pkg::N_REGIONS-1:0]                 out_wr_valid,
  input  logic [rdma_wr_pkg::N_REGIONS-1:0]                 out_wr_ready,
  output rdma_wr_pkg::data_t [rdma_wr_pkg::N_REGIONS-1:0]   out_wr_data,
  output rdma_wr_pkg::keep_t [rdma_wr_pkg::N_REGIONS-1:0]   out_wr_keep,
  output logic [rdma_wr_pkg::N_REGIONS-1:0]                 out_wr_last,
  // Per-region flow control
  output logic [rdma_wr_pkg::N_REGIONS-1:0]                 wr_rdy
);

  import rdma_wr_pkg::*;

  // Beats-minus-one countdown width
  typedef logic [LEN_BITS-BEAT_LOG_BITS-1:0] beat_cnt_t;

  typedef enum logic {
    ST_IDLE,
    ST_FWD
  } state_t;

  // Command side
  logic                           req_fire;
  logic [N_REGIONS-1:0]           cmd_in_valid;
  logic [N_REGIONS-1:0]           cmd_in_ready;
  logic [N_REGIONS-1:0][LEN_BITS:0] cmd_out_data;

  // Sequence queue, entry is {last, vfid, len}
  logic                               seq_in_ready;
  logic                               seq_out_valid;
  logic                               seq_out_ready;
  logic [LEN_BITS+N_REGIONS_BITS:0]   seq_out_data;
  logic                               seq_last;
  vfid_t                              seq_vfid;
  len_t                               seq_len;

  // Data side
  logic [N_REGIONS-1:0] fifo_in_valid;
  logic [N_REGIONS-1:0] fifo_in_ready;
  count_t               fifo_count [N_REGIONS];

  // FSM and current command
  state_t    state_q;
  state_t    state_d;
  vfid_t     vfid_q;
  vfid_t     vfid_d;
  beat_cnt_t cnt_q;
  beat_cnt_t cnt_d;
  logic      last_q;
  logic      last_d;

  logic beat_acc;
  logic final_beat;
  logic beat_last;

  // ceil(len/8) - 1, len is never zero
  function automatic beat_cnt_t beats_m1(input len_t len);
    if (len[BEAT_LOG_BITS-1:0] != '0) begin
      return len[LEN_BITS-1:BEAT_LOG_BITS];
    end else begin
      return len[LEN_BITS-1:BEAT_LOG_BITS] - 1'b1;
    end
  endfunction

  // --------------------------------------------------
  // Command routing
  // --------------------------------------------------

  // Needs room in both the sequence queue and the target region queue
  assign req_ready = seq_in_ready && cmd_in_ready[req_vfid];
  assign req_fire  = req_valid && req_ready;

  for (genvar i = 0; i < N_REGIONS; i++) begin : g_cmd
    assign cmd_in_valid[i] = req_fire && (req_vfid == vfid_t'(i));

    meta_fifo #(
      .WIDTH(LEN_BITS + 1),
      .DEPTH(CMD_QUEUE_DEPTH)
    ) u_cmd_queue (
      .aclk     (aclk),
      .aresetn  (aresetn),
      .in_valid (cmd_in_valid[i]),
      .in_ready (cmd_in_ready[i]),
      .in_data  ({req_last, req_len}),
      .out_valid(out_req_valid[i]),
      .out_ready(out_req_ready[i]),
      .out_data (cmd_out_data[i])
    );

    assign out_req_last[i] = cmd_out_data[i][LEN_BITS];
    assign out_req_len[i]  = cmd_out_data[i][LEN_BITS-1:0];
  end

  // Same command, in arrival order, for the data sequencer
  meta_fifo #(
    .WIDTH(LEN_BITS + N_REGIONS_BITS + 1),
    .DEPTH(N_OUTSTANDING)
  ) u_seq_queue (
    .aclk     (aclk),
    .aresetn  (aresetn),
    .in_valid (req_fire),
    .in_ready (seq_in_ready),
    .in_data  ({req_last, req_vfid, req_len}),
    .out_valid(seq_out_valid),
    .out_ready(seq_out_ready),
    .out_data (seq_out_data)
  );

  assign seq_last = seq_out_data[LEN_BITS+N_REGIONS_BITS];
  assign seq_vfid = seq_out_data[LEN_BITS+N_REGIONS_BITS-1:LEN_BITS];
  assign seq_len  = seq_out_data[LEN_BITS-1:0];

  // --------------------------------------------------
  // Data sequencing
  // --------------------------------------------------

  // wr_ready is low in idle, so no beat is taken there
  assign beat_acc   = wr_valid && wr_ready;
  assign final_beat = (state_q == ST_FWD) && beat_acc && (cnt_q == '0);
  assign beat_last  = (state_q == ST_FWD) && last_q && (cnt_q == '0);

  // Pop from idle, or right on the final beat so no cycle is lost
  assign seq_out_ready = seq_out_valid && ((state_q == ST_IDLE) || final_beat);

  always_comb begin
    state_d = state_q;
    vfid_d  = vfid_q;
    cnt_d   = cnt_q;
    last_d  = last_q;

    if (seq_out_ready) begin
      // Load next command
      state_d = ST_FWD;
      vfid_d  = seq_vfid;
      cnt_d   = beats_m1(seq_len);
      last_d  = seq_last;
    end else if (final_beat) begin
      state_d = ST_IDLE;
    end else if (beat_acc) begin
      cnt_d = cnt_q - 1'b1;
    end
  end

  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      state_q <= ST_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // Current command fields, only meaningful in forwarding
  always_ff @(posedge aclk) begin
    vfid_q <= vfid_d;
    cnt_q  <= cnt_d;
    last_q <= last_d;
  end

  // Input ready follows the selected FIFO
  assign wr_ready = (state_q == ST_FWD) && fifo_in_ready[vfid_q];

  // --------------------------------------------------
  // Region data FIFOs
  // --------------------------------------------------

  for (genvar i = 0; i < N_REGIONS; i++) begin : g_data
    assign fifo_in_valid[i] = (state_q == ST_FWD) && (vfid_q == vfid_t'(i)) && wr_valid;

    axis_data_fifo u_data_fifo (
      .aclk     (aclk),
      .aresetn  (aresetn),
      .in_valid (fifo_in_valid[i]),
      .in_ready (fifo_in_ready[i]),
      .in_data  (wr_data),
      .in_keep  (wr_keep),
      .in_last  (beat_last),
      .out_valid(out_wr_valid[i]),
      .out_ready(out_wr_ready[i]),
      .out_data (out_wr_data[i]),
      .out_keep (out_wr_keep[i]),
      .out_last (out_wr_last[i]),
      .count    (fifo_count[i])
    );

    // Region may take more data while at or below threshold
    assign wr_rdy[i] = (fifo_count[i] <= count_t'(WR_THRS));
  end

endmodule

//--- tb_rdma_wr_demux.sv
// RDMA write demux testbench
`timescale 1ns/1ps

module tb_rdma_wr_demux;

  import rdma_wr_pkg::*;

  // --------------------------------------------------
  // Constants
  // --------------------------------------------------

  localparam int    CLK_PERIOD   = 8;
  localparam int    RESET_CYCLES = 10;
  localparam int    SEED         = 98276;
  localparam int    MAX_CMDS     = 64;
  localparam int    MAX_BEATS    = 4096;
  // Sink modes selected by the header line
  localparam int    MODE_READY   = 0;
  localparam int    MODE_RANDOM  = 1;
  localparam int    MODE_STALL   = 2;
  // Cycles the stalled region keeps its data ready low
  localparam int    STALL_CYCLES = 300;
  localparam string STIM_FILE    = "rdma_wr_stimulus.txt";

  // DUT signals
  logic                       aclk;
  logic                       aresetn;
  logic                       req_valid;
  logic                       req_ready;
  vfid_t                      req_vfid;
  len_t                       req_len;
  logic                       req_last;
  logic                       wr_valid;
  logic                       wr_ready;
  data_t                      wr_data;
  keep_t                      wr_keep;
  logic [N_REGIONS-1:0]       out_req_valid;
  logic [N_REGIONS-1:0]       out_req_ready;
  len_t [N_REGIONS-1:0]       out_req_len;
  logic [N_REGIONS-1:0]       out_req_last;
  logic [N_REGIONS-1:0]       out_wr_valid;
  logic [N_REGIONS-1:0]       out_wr_ready;
  data_t [N_REGIONS-1:0]      out_wr_data;
  keep_t [N_REGIONS-1:0]      out_wr_keep;
  logic [N_REGIONS-1:0]       out_wr_last;
  logic [N_REGIONS-1:0]       wr_rdy;

  // Expected commands and beats, in input order
  vfid_t cmd_vfid  [MAX_CMDS];
  len_t  cmd_len   [MAX_CMDS];
  logic  cmd_last  [MAX_CMDS];
  vfid_t beat_vfid [MAX_BEATS];
  data_t beat_data [MAX_BEATS];
  logic  beat_last [MAX_BEATS];

  // Per-region scan position and beats held in the data FIFO
  int cmd_ptr  [N_REGIONS];
  int beat_ptr [N_REGIONS];
  int pending  [N_REGIONS];

  int   n_cmds     = 0;
  int   n_beats    = 0;
  int   mode       = MODE_READY;
  int   stall_rgn  = 0;
  int   cur_beat   = 0;
  int   errors     = 0;
  int   cmds_seen  = 0;
  int   beats_seen = 0;
  int   cycles     = 0;
  int   limit      = 2000;
  logic running    = 1'b0;

  rdma_wr_demux DUT (.*);

  initial begin
    aclk = 1'b0;
    forever begin
      #(CLK_PERIOD / 2) aclk = ~aclk;
    end
  end

  // --------------------------------------------------
  // Stimulus
  // --------------------------------------------------

  // Counter pattern, upper half inverted
  function automatic data_t beat_pattern(input int idx);
    logic [31:0] w;
    w = 32'(idx);
    return {~w, w};
  endfunction

  task automatic load_stimulus();
    int    fd;
    int    v;
    int    l;
    int    f;
    int    a;
    int    b;
    int    k;
    int    nb;
    string line;
    fd = $fopen(STIM_FILE, "r");
    if (fd == 0) begin
      $display("Could not open the stimulus file %s", STIM_FILE);
      errors++;
      return;
    end
    while (!$feof(fd)) begin
      line = "";
      void'($fgets(line, fd));
      if ($sscanf(line, "mode %d %d", a, b) == 2) begin
        mode      = a;
        stall_rgn = b;
      end else if ($sscanf(line, "%d %d %d", v, l, f) == 3) begin
        cmd_vfid[n_cmds] = vfid_t'(v);
        cmd_len[n_cmds]  = len_t'(l);
        cmd_last[n_cmds] = (f != 0);
        // 8 bytes per beat, partial beat rounds up
        nb = (l + 7) / 8;
        for (k = 0; k < nb; k++) begin
          beat_vfid[n_beats] = vfid_t'(v);
          beat_data[n_beats] = beat_pattern(n_beats);
          // tlast only closes a command flagged as last
          beat_last[n_beats] = (f != 0) && (k == nb - 1);
          n_beats++;
        end
        n_cmds++;
      end
    end
    $fclose(fd);
  endtask

  // Ready is looked at just after the falling edge, where it is settled
  task automatic drive_commands();
    int i;
    for (i = 0; i < n_cmds; i++) begin
      req_valid = 1'b1;
      req_vfid  = cmd_vfid[i];
      req_len   = cmd_len[i];
      req_last  = cmd_last[i];
      #1;
      while (!req_ready) begin
        @(negedge aclk);
        #1;
      end
      @(negedge aclk);
    end
    req_valid = 1'b0;
  endtask

  task automatic drive_beats();
    int i;
    for (i = 0; i < n_beats; i++) begin
      cur_beat = i;
      wr_valid = 1'b1;
      wr_data  = beat_data[i];
      wr_keep  = '1;
      #1;
      while (!wr_ready) begin
        @(negedge aclk);
        #1;
      end
      @(negedge aclk);
    end
    wr_valid = 1'b0;
  endtask

  // Region ready inputs, plus the write-ready flag check
  task automatic run_sinks();
    int   k;
    int   r;
    logic exp;
    k = 0;
    forever begin
      for (r = 0; r < N_REGIONS; r++) begin
        // Fill level after the last edge decides the flag
        exp = (pending[r] <= WR_THRS);
        if (wr_rdy[r] !== exp) begin
          $display("ERROR wr_rdy[%0d]: expected %h, got %h", r, exp, wr_rdy[r]);
          errors++;
        end
        if (mode == MODE_READY) begin
          out_req_ready[r] = 1'b1;
          out_wr_ready[r]  = 1'b1;
        end else begin
          out_req_ready[r] = ($urandom % 4) != 0;
          out_wr_ready[r]  = ($urandom % 4) != 0;
        end
        if (mode == MODE_STALL && r == stall_rgn && k < STALL_CYCLES) begin
          out_wr_ready[r] = 1'b0;
        end
      end
      k++;
      @(negedge aclk);
    end
  endtask

  // --------------------------------------------------
  // Checks
  // --------------------------------------------------

  task automatic check_idle_outputs();
    if (out_req_valid !== '0) begin
      $display("ERROR out_req_valid: expected %h, got %h", {N_REGIONS{1'b0}}, out_req_valid);
      errors++;
    end
    if (out_wr_valid !== '0) begin
      $display("ERROR out_wr_valid: expected %h, got %h", {N_REGIONS{1'b0}}, out_wr_valid);
      errors++;
    end
    if (wr_rdy !== '1) begin
      $display("ERROR wr_rdy: expected %h, got %h", {N_REGIONS{1'b1}}, wr_rdy);
      errors++;
    end
    if (wr_ready !== 1'b0) begin
      $display("ERROR wr_ready: expected %h, got %h", 1'b0, wr_ready);
      errors++;
    end
  endtask

  task automatic check_cmd(input int r);
    int j;
    j = cmd_ptr[r];
    while (j < n_cmds && cmd_vfid[j] != vfid_t'(r)) j++;
    if (j >= n_cmds) begin
      $display("Region %0d put out a command that was never sent to it", r);
      errors++;
    end else begin
      if (out_req_len[r] !== cmd_len[j]) begin
        $display("ERROR out_req_len[%0d]: expected %h, got %h", r, cmd_len[j], out_req_len[r]);
        errors++;
      end
      if (out_req_last[r] !== cmd_last[j]) begin
        $display("ERROR out_req_last[%0d]: expected %h, got %h", r, cmd_last[j],
                 out_req_last[r]);
        errors++;
      end
      cmd_ptr[r] = j + 1;
    end
    cmds_seen++;
  endtask

  task automatic check_beat(input int r);
    int j;
    j = beat_ptr[r];
    while (j < n_beats && beat_vfid[j] != vfid_t'(r)) j++;
    if (j >= n_beats) begin
      $display("Region %0d put out a data beat that belongs to no command of its own", r);
      errors++;
    end else begin
      if (out_wr_data[r] !== beat_data[j]) begin
        $display("ERROR out_wr_data[%0d]: expected %h, got %h", r, beat_data[j], out_wr_data[r]);
        errors++;
      end
      if (out_wr_keep[r] !== keep_t'('1)) begin
        $display("ERROR out_wr_keep[%0d]: expected %h, got %h", r, keep_t'('1), out_wr_keep[r]);
        errors++;
      end
      if (out_wr_last[r] !== beat_last[j]) begin
        $display("ERROR out_wr_last[%0d]: expected %h, got %h", r, beat_last[j], out_wr_last[r]);
        errors++;
      end
      beat_ptr[r] = j + 1;
    end
    beats_seen++;
    pending[r]--;
  endtask

  // Handshakes looked at once the inputs have settled, they fire on the next rising edge
  always begin
    @(negedge aclk);
    #1;
    if (running) begin
      if (wr_valid && wr_ready) begin
        pending[beat_vfid[cur_beat]]++;
      end
      for (int r = 0; r < N_REGIONS; r++) begin
        if (out_req_valid[r] && out_req_ready[r]) begin
          check_cmd(r);
        end
        if (out_wr_valid[r] && out_wr_ready[r]) begin
          check_beat(r);
        end
      end
    end
  end

  // Run limit
  always @(posedge aclk) begin
    cycles++;
    if (cycles > limit) begin
      $display("Run timed out after %0d cycles, %0d of %0d beats delivered",
               cycles, beats_seen, n_beats);
      $display("Test failures found");
      $finish;
    end
  end

  // --------------------------------------------------
  // Main sequence
  // --------------------------------------------------

  initial begin
    aresetn       = 1'b0;
    req_valid     = 1'b0;
    req_vfid      = '0;
    req_len       = '0;
    req_last      = 1'b0;
    wr_valid      = 1'b0;
    wr_data       = '0;
    wr_keep       = '0;
    out_req_ready = '0;
    out_wr_ready  = '0;
    for (int r = 0; r < N_REGIONS; r++) begin
      cmd_ptr[r]  = 0;
      beat_ptr[r] = 0;
      pending[r]  = 0;
    end
    void'($urandom(SEED));
    load_stimulus();
    limit = 40 * n_beats + 2000;

    // Outputs idle while reset is held
    for (int i = 0; i < RESET_CYCLES; i++) begin
      @(negedge aclk);
      if (i >= 1) begin
        check_idle_outputs();
      end
    end
    aresetn = 1'b1;
    @(negedge aclk);
    check_idle_outputs();
    if (req_ready !== 1'b1) begin
      $display("ERROR req_ready: expected %h, got %h", 1'b1, req_ready);
      errors++;
    end

    running = 1'b1;
    fork
      drive_commands();
      drive_beats();
      run_sinks();
    join_none

    while (cmds_seen < n_cmds || beats_seen < n_beats) @(negedge aclk);
    // Idle time to catch stray outputs
    repeat (20) @(negedge aclk);
    for (int r = 0; r < N_REGIONS; r++) begin
      if (pending[r] != 0) begin
        $display("Region %0d still holds %0d beats at the end", r, pending[r]);
        errors++;
      end
    end

    $display("Checked %0d commands and %0d beats in %0d cycles, %0d errors",
             cmds_seen, beats_seen, cycles, errors);
    if (errors == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

//--- rdma_wr_stimulus.txt
# Header: mode <0 always ready, 1 random, 2 region stalled> <stalled region>
# Commands: <vfid> <length in bytes, decimal> <last flag>
mode 2 2
0 64 1
1 1 1
2 200 0
2 72 1
3 8 1
0 13 0
0 16 1
1 100 1
2 9 1
3 1000 1
0 7 1
1 24 0
1 33 1
3 48 0
3 2 1
2 40 1
0 120 1
1 8 1
2 17 0
3 57 1

//--- rdma_wr_demux.f
rdma_wr_pkg.sv
meta_fifo.sv
axis_data_fifo.sv
rdma_wr_demux.sv
tb_rdma_wr_demux.sv

//--- Makefile
# Verilator build and run for the RDMA write demux

VERILATOR ?= verilator
TOP       ?= tb_rdma_wr_demux
FILELIST  ?= rdma_wr_demux.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0

SRCS    := $(shell cat $(FILELIST))
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes
$(SIM_BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN) | tee $(LOG)
	@grep -q "All tests passed!" $(LOG) || (echo "Simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
